/* mem_pkg.sv */
package mem_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  mask_t;   // one bit per byte lane.
    typedef logic [2:0]  route_t;

    // device windows, inclusive bounds.
    localparam addr_t SERIAL_START = 64'h0000_0000_a000_03f8;
    localparam addr_t SERIAL_END   = 64'h0000_0000_a000_03ff;
    localparam addr_t RTC_START    = 64'h0000_0000_a000_0048;
    localparam addr_t RTC_END      = 64'h0000_0000_a000_004f;

    localparam addr_t RAM_BASE     = 64'h0000_0000_8000_0000;

    localparam route_t ROUTE_UNCACHED = 3'b001;
    localparam route_t ROUTE_CACHED   = 3'b100;

    // byte enables widened to a bit mask.
    function automatic data_t mask_bits(mask_t mask);
        data_t bits;
        for (int i = 0; i < 8; i++) begin
            bits[8*i +: 8] = {8{mask[i]}};
        end
        return bits;
    endfunction

    function automatic data_t merge_bytes(data_t old_word, data_t new_word, mask_t mask);
        data_t bits;
        bits = mask_bits(mask);
        return (old_word & ~bits) | (new_word & bits);
    endfunction

endpackage

/* uncache_mmio.sv */
`timescale 1ns/1ps

module uncache_mmio import mem_pkg::*; (
    output route_t mmio_sign,

    input  addr_t  core_addr,
    input  data_t  core_data,
    input  mask_t  core_mask,
    input  logic   core_we,
    input  logic   core_re,
    output data_t  in_core_data,
    output logic   in_core_finish,

    output addr_t  arb_addr,
    output data_t  arb_data,
    output mask_t  arb_mask,
    output logic   arb_we,
    output logic   arb_re,
    input  data_t  in_arb_data,
    input  logic   in_arb_finish,

    output addr_t  dcache_addr,
    output data_t  dcache_data,
    output mask_t  dcache_mask,
    output logic   dcache_we,
    output logic   dcache_re,
    input  data_t  in_dcache_data,
    input  logic   in_dcache_finish
);
    logic start;
    logic in_serial;
    logic in_rtc;
    logic uncache;

    assign start     = core_we || core_re;
    assign in_serial = (core_addr >= SERIAL_START) && (core_addr <= SERIAL_END);
    assign in_rtc    = (core_addr >= RTC_START) && (core_addr <= RTC_END);
    assign uncache   = start && (in_serial || in_rtc);
    assign mmio_sign = uncache ? ROUTE_UNCACHED : ROUTE_CACHED;

    // device path, store data masked per byte.
    assign arb_addr = uncache ? core_addr : '0;
    assign arb_data = uncache ? (core_data & mask_bits(core_mask)) : '0;
    assign arb_mask = uncache ? core_mask : '0;
    assign arb_we   = uncache && core_we;
    assign arb_re   = uncache && core_re;

    assign dcache_addr = uncache ? '0 : core_addr;
    assign dcache_data = uncache ? '0 : core_data;
    assign dcache_mask = uncache ? '0 : core_mask;
    assign dcache_we   = !uncache && core_we;
    assign dcache_re   = !uncache && core_re;

    assign in_core_data   = uncache ? in_arb_data : in_dcache_data;
    assign in_core_finish = uncache ? in_arb_finish : in_dcache_finish;

endmodule

/* dcache.sv */
`timescale 1ns/1ps

module dcache import mem_pkg::*; #(
    parameter int CACHE_LINES = 16
) (
    input  logic  clk,
    input  logic  reset,

    input  addr_t dcache_addr,
    input  data_t dcache_data,
    input  mask_t dcache_mask,
    input  logic  dcache_we,
    input  logic  dcache_re,
    output data_t in_dcache_data,
    output logic  in_dcache_finish,

    output addr_t mem_addr,
    output data_t mem_data,
    output mask_t mem_mask,
    output logic  mem_we,
    output logic  mem_re,
    input  data_t in_mem_data,
    input  logic  in_mem_finish
);
    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = 64 - 3 - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_REFILL,
        S_WRITE,
        S_RESP
    } state_t;

    state_t state_q;

    // held copy of the core request.
    addr_t req_addr_q;
    data_t req_data_q;
    mask_t req_mask_q;
    logic  req_we_q;
    data_t rdata_q;

    tag_t  tag_q [CACHE_LINES];
    data_t data_q [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_q;

    idx_t idx;
    tag_t tag;
    logic hit;

    assign idx = req_addr_q[3 +: IDX_W];
    assign tag = req_addr_q[63 -: TAG_W];
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // ==========================================================
    // control
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (dcache_we || dcache_re) state_q <= S_LOOKUP;
                end
                S_LOOKUP: begin
                    if (req_we_q)  state_q <= S_WRITE;   // write-through, no allocate.
                    else if (hit)  state_q <= S_RESP;
                    else           state_q <= S_REFILL;
                end
                S_REFILL: begin
                    if (in_mem_finish) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= S_RESP;
                    end
                end
                S_WRITE: begin
                    if (in_mem_finish) state_q <= S_RESP;
                end
                S_RESP: state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // ==========================================================
    // arrays and request capture
    // ==========================================================
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE) begin
            req_addr_q <= dcache_addr;
            req_data_q <= dcache_data;
            req_mask_q <= dcache_mask;
            req_we_q   <= dcache_we;
        end
        if (state_q == S_LOOKUP && !req_we_q && hit) begin
            rdata_q <= data_q[idx];
        end
        if (state_q == S_REFILL && in_mem_finish) begin
            data_q[idx] <= in_mem_data;
            tag_q[idx]  <= tag;
            rdata_q     <= in_mem_data;
        end
        // store hit keeps the line in step with RAM.
        if (state_q == S_WRITE && in_mem_finish && hit) begin
            data_q[idx] <= merge_bytes(data_q[idx], req_data_q, req_mask_q);
        end
    end

    assign mem_addr = req_addr_q;
    assign mem_data = req_data_q;
    assign mem_mask = req_we_q ? req_mask_q : '1;   // refill reads the whole word.
    assign mem_we   = (state_q == S_WRITE);
    assign mem_re   = (state_q == S_REFILL);

    assign in_dcache_data   = rdata_q;
    assign in_dcache_finish = (state_q == S_RESP);

    finish_needs_request: assert property (@(posedge clk) disable iff (reset)
        in_dcache_finish |-> (dcache_we || dcache_re))
        else $error("dcache finish without an active request");

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    input  addr_t arb_addr,
    input  data_t arb_data,
    input  mask_t arb_mask,
    input  logic  arb_we,
    input  logic  arb_re,
    output data_t in_arb_data,
    output logic  in_arb_finish,

    input  addr_t mem_addr,
    input  data_t mem_data,
    input  mask_t mem_mask,
    input  logic  mem_we,
    input  logic  mem_re,
    output data_t in_mem_data,
    output logic  in_mem_finish,

    output addr_t bus_addr,
    output data_t bus_data,
    output mask_t bus_mask,
    output logic  bus_we,
    output logic  bus_re,
    input  data_t in_bus_data,
    input  logic  in_bus_finish
);
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_UNCACHED,
        ARB_CACHE
    } arb_state_t;

    arb_state_t state_q;
    logic arb_req;
    logic mem_req;
    logic grant_unc;
    logic grant_mem;

    assign arb_req = arb_we || arb_re;
    assign mem_req = mem_we || mem_re;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (arb_req)      state_q <= ARB_UNCACHED;   // uncached first.
                    else if (mem_req) state_q <= ARB_CACHE;
                end
                ARB_UNCACHED: if (!arb_req) state_q <= ARB_IDLE;
                ARB_CACHE:    if (!mem_req) state_q <= ARB_IDLE;
                default:      state_q <= ARB_IDLE;
            endcase
        end
    end

    assign grant_unc = (state_q == ARB_UNCACHED);
    assign grant_mem = (state_q == ARB_CACHE);

    assign bus_addr = grant_unc ? arb_addr : (grant_mem ? mem_addr : '0);
    assign bus_data = grant_unc ? arb_data : (grant_mem ? mem_data : '0);
    assign bus_mask = grant_unc ? arb_mask : (grant_mem ? mem_mask : '0);
    assign bus_we   = (grant_unc && arb_we) || (grant_mem && mem_we);
    assign bus_re   = (grant_unc && arb_re) || (grant_mem && mem_re);

    assign in_arb_data   = grant_unc ? in_bus_data : '0;
    assign in_arb_finish = grant_unc && in_bus_finish;
    assign in_mem_data   = grant_mem ? in_bus_data : '0;
    assign in_mem_finish = grant_mem && in_bus_finish;

    // the core keeps one access in flight.
    single_requester: assert property (@(posedge clk) disable iff (reset)
        !(arb_req && mem_req))
        else $error("cache and uncached port request together");

endmodule

/* bus_slaves.sv */
`timescale 1ns/1ps

module bus_slaves import mem_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic       clk,
    input  logic       reset,

    input  addr_t      bus_addr,
    input  data_t      bus_data,
    input  mask_t      bus_mask,
    input  logic       bus_we,
    input  logic       bus_re,
    output data_t      in_bus_data,
    output logic       in_bus_finish,

    output logic       serial_valid,
    output logic [7:0] serial_byte
);
    localparam int    RAM_AW    = $clog2(RAM_WORDS);
    localparam addr_t RAM_LIMIT = RAM_BASE + addr_t'(RAM_WORDS) * 8;   // exclusive.

    data_t ram [RAM_WORDS];

    logic  req;
    logic  sel_ram;
    logic  sel_serial;
    logic  sel_rtc;
    logic  fire;
    logic  [1:0] lat;
    logic  [1:0] cnt_q;
    logic  finish_q;
    addr_t ram_off;
    logic  [RAM_AW-1:0] ram_idx;
    data_t read_word;
    data_t rdata_q;
    data_t rtc_q;

    // ==========================================================
    // decode
    // ==========================================================
    assign req        = bus_we || bus_re;
    assign sel_ram    = (bus_addr >= RAM_BASE) && (bus_addr < RAM_LIMIT);
    assign sel_serial = (bus_addr >= SERIAL_START) && (bus_addr <= SERIAL_END);
    assign sel_rtc    = (bus_addr >= RTC_START) && (bus_addr <= RTC_END);

    assign ram_off = bus_addr - RAM_BASE;
    assign ram_idx = ram_off[3 +: RAM_AW];

    assign lat  = sel_ram ? 2'd2 : 2'd1;   // unmapped answers like a device.
    assign fire = req && !finish_q && (cnt_q + 2'd1 == lat);

    always_comb begin
        read_word = '0;
        if (bus_re && sel_ram) read_word = ram[ram_idx];
        else if (bus_re && sel_rtc) read_word = rtc_q;
    end

    // ==========================================================
    // latency and devices
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q        <= '0;
            finish_q     <= 1'b0;
            serial_valid <= 1'b0;
            rtc_q        <= '0;
        end else begin
            rtc_q        <= rtc_q + 64'd1;
            finish_q     <= fire;
            serial_valid <= fire && bus_we && sel_serial;
            if (!req || finish_q) cnt_q <= '0;
            else                  cnt_q <= cnt_q + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (sel_ram && bus_we) begin
                ram[ram_idx] <= merge_bytes(ram[ram_idx], bus_data, bus_mask);
            end
            if (sel_serial && bus_we) begin
                serial_byte <= bus_data[7:0];
            end
            rdata_q <= read_word;   // writes return zero.
        end
    end

    assign in_bus_data   = rdata_q;
    assign in_bus_finish = finish_q;

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; #(
    parameter int CACHE_LINES = 16,
    parameter int RAM_WORDS   = 1024
) (
    input  logic       clk,
    input  logic       reset,

    input  addr_t      core_addr,
    input  data_t      core_data,
    input  mask_t      core_mask,
    input  logic       core_we,
    input  logic       core_re,
    output data_t      in_core_data,
    output logic       in_core_finish,

    output route_t     mmio_sign,
    output logic       serial_valid,
    output logic [7:0] serial_byte
);
    // router to arbiter.
    addr_t arb_addr;
    data_t arb_data;
    mask_t arb_mask;
    logic  arb_we;
    logic  arb_re;
    data_t in_arb_data;
    logic  in_arb_finish;

    // router to cache.
    addr_t dcache_addr;
    data_t dcache_data;
    mask_t dcache_mask;
    logic  dcache_we;
    logic  dcache_re;
    data_t in_dcache_data;
    logic  in_dcache_finish;

    // cache to arbiter.
    addr_t mem_addr;
    data_t mem_data;
    mask_t mem_mask;
    logic  mem_we;
    logic  mem_re;
    data_t in_mem_data;
    logic  in_mem_finish;

    // system bus.
    addr_t bus_addr;
    data_t bus_data;
    mask_t bus_mask;
    logic  bus_we;
    logic  bus_re;
    data_t in_bus_data;
    logic  in_bus_finish;

    uncache_mmio uncache_mmio_i (.*);

    dcache #(.CACHE_LINES(CACHE_LINES)) dcache_i (.*);

    mem_arbiter mem_arbiter_i (.*);

    bus_slaves #(.RAM_WORDS(RAM_WORDS)) bus_slaves_i (.*);

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

    localparam int CACHE_LINES    = 16;
    localparam int RAM_WORDS      = 1024;
    localparam int ACCESS_TIMEOUT = 200;
    localparam int RANDOM_OPS     = 200;

    logic       clk;
    logic       reset;
    addr_t      core_addr;
    data_t      core_data;
    mask_t      core_mask;
    logic       core_we;
    logic       core_re;
    data_t      in_core_data;
    logic       in_core_finish;
    route_t     mmio_sign;
    logic       serial_valid;
    logic [7:0] serial_byte;

    logic [7:0] ram_model [addr_t];   // sparse, one entry per byte.

    mem_subsys_top #(
        .CACHE_LINES(CACHE_LINES),
        .RAM_WORDS(RAM_WORDS)
    ) mem_subsys_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==========================================================
    // helpers
    // ==========================================================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic route_t expected_route(addr_t addr);
        if ((addr >= SERIAL_START && addr <= SERIAL_END) ||
            (addr >= RTC_START && addr <= RTC_END)) begin
            return ROUTE_UNCACHED;
        end
        return ROUTE_CACHED;
    endfunction

    function automatic void model_store(addr_t addr, data_t data, mask_t mask);
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) ram_model[addr + addr_t'(i)] = data[8*i +: 8];
        end
    endfunction

    function automatic data_t model_load(addr_t addr);
        data_t word;
        word = '0;
        for (int i = 0; i < 8; i++) begin
            if (ram_model.exists(addr + addr_t'(i))) word[8*i +: 8] = ram_model[addr + addr_t'(i)];
        end
        return word;
    endfunction

    // tag_sel picks the alias, idx_sel the cache line.
    function automatic addr_t test_addr(int tag_sel, int idx_sel);
        int word;
        word = (tag_sel * CACHE_LINES + idx_sel) % RAM_WORDS;
        return RAM_BASE + addr_t'(word * 8);
    endfunction

    // called just after a rising edge; returns the same way.
    task automatic run_access(input string name, input addr_t addr, input data_t wdata,
                              input mask_t mask, input logic write,
                              output data_t rdata, output int pulses);
        int     cycles;
        logic   done;
        route_t route;
        cycles    = 0;
        done      = 1'b0;
        pulses    = 0;
        rdata     = '0;
        route     = expected_route(addr);
        core_addr = addr;
        core_data = wdata;
        core_mask = mask;
        core_we   = write;
        core_re   = !write;
        while (!done) begin
            @(negedge clk);
            check_value({name, " route"}, data_t'(route), data_t'(mmio_sign));
            if (serial_valid) pulses++;
            if (in_core_finish) begin
                done  = 1'b1;
                rdata = in_core_data;
            end else begin
                cycles++;
                if (cycles >= ACCESS_TIMEOUT) fail_run({"no finish within timeout on ", name});
            end
        end
        @(posedge clk);
        #1;
        core_we   = 1'b0;
        core_re   = 1'b0;
        core_addr = '0;
        core_data = '0;
        core_mask = '0;
        @(posedge clk);   // one idle cycle between accesses.
        #1;
    endtask

    // ==========================================================
    // stimulus
    // ==========================================================
    initial begin
        data_t rdata;
        data_t wdata;
        data_t first;
        mask_t mask;
        addr_t addr;
        int    pulses;
        reset     = 1'b1;
        core_addr = '0;
        core_data = '0;
        core_mask = '0;
        core_we   = 1'b0;
        core_re   = 1'b0;
        void'($urandom(32'h2df));
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (8) begin
            @(negedge clk);
            check_value("idle finish", 64'd0, data_t'(in_core_finish));
            check_value("idle serial", 64'd0, data_t'(serial_valid));
        end
        @(posedge clk);
        #1;

        // full words first, so every byte in the model is known.
        for (int t = 0; t < 4; t++) begin
            for (int k = 0; k < 2; k++) begin
                addr  = test_addr(t, (k == 0) ? 1 : 5);
                wdata = {$urandom, $urandom};
                model_store(addr, wdata, 8'hff);
                run_access("ram init", addr, wdata, 8'hff, 1'b1, rdata, pulses);
            end
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            addr = test_addr($urandom_range(0, 3), ($urandom_range(0, 1) == 0) ? 1 : 5);
            if ($urandom_range(0, 1) == 1) begin
                wdata = {$urandom, $urandom};
                mask  = mask_t'($urandom);
                model_store(addr, wdata, mask);
                run_access("ram store", addr, wdata, mask, 1'b1, rdata, pulses);
            end else begin
                run_access("ram load", addr, '0, 8'hff, 1'b0, rdata, pulses);
                check_value("ram read-after-write", model_load(addr), rdata);
            end
            check_value("ram serial quiet", 64'd0, data_t'(pulses));
        end

        // store hit, evict by a conflicting load, then a write miss.
        run_access("coherence load", test_addr(0, 1), '0, 8'hff, 1'b0, rdata, pulses);
        wdata = {$urandom, $urandom};
        model_store(test_addr(0, 1), wdata, 8'hff);
        run_access("coherence store", test_addr(0, 1), wdata, 8'hff, 1'b1, rdata, pulses);
        run_access("coherence evict", test_addr(2, 1), '0, 8'hff, 1'b0, rdata, pulses);
        run_access("coherence reload", test_addr(0, 1), '0, 8'hff, 1'b0, rdata, pulses);
        check_value("write-through hit", model_load(test_addr(0, 1)), rdata);
        wdata = {$urandom, $urandom};
        mask  = mask_t'($urandom);
        model_store(test_addr(2, 1), wdata, mask);
        run_access("coherence miss store", test_addr(2, 1), wdata, mask, 1'b1, rdata, pulses);
        run_access("coherence miss load", test_addr(2, 1), '0, 8'hff, 1'b0, rdata, pulses);
        check_value("write-through miss", model_load(test_addr(2, 1)), rdata);

        repeat (3) begin
            wdata = {$urandom, $urandom};
            mask  = mask_t'($urandom);
            run_access("serial store", SERIAL_START, wdata, mask, 1'b1, rdata, pulses);
            check_value("serial pulses", 64'd1, data_t'(pulses));
            check_value("serial byte", data_t'(mask[0] ? wdata[7:0] : 8'h00),
                        data_t'(serial_byte));
        end

        run_access("rtc load", RTC_START, '0, 8'hff, 1'b0, first, pulses);
        run_access("rtc load", RTC_START, '0, 8'hff, 1'b0, rdata, pulses);
        check_value("rtc nonzero", 64'd1, data_t'(first != 0));
        check_value("rtc increasing", 64'd1, data_t'(rdata > first));

        $display("Everything OK");
        $finish;
    end

endmodule

/* files.f */
mem_pkg.sv
uncache_mmio.sv
dcache.sv
mem_arbiter.sv
bus_slaves.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status is the simulator's.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_mem_subsys \
    -f files.f \
    -o tb_mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit $status
